// File: adc_capture_consts.svh
/*
  adc capture core constants: widths, source latencies,
  control word bit positions and frame block size
*/
`ifndef ADC_CAPTURE_CONSTS_SVH
`define ADC_CAPTURE_CONSTS_SVH

// packed i/q sample, i in the upper half
`define ADC_IQ_W 32
`define ADC_HALF_W 16

// one output word, two routed halves
`define FRAME_W 64

// latency countdown width
`define LAT_CNT_W 8

// frame block is 2**ALIGN_W words, 64 here
`define ALIGN_W 6

// source latencies in clk_245_76MHz cycles
`define DDS_CHIRP_DELAY 4
`define DDS_WFRM_DELAY 19
`define DDS_WFRM_DELAY_END 2

// control word fields, 2 bits each
`define CW_ROUTE_L_LSB 0
`define CW_ROUTE_U_LSB 4
`define CW_SOURCE_LSB 8

`endif

// File: adc_capture_pkg.sv
/*
  adc capture types: half-word route codes and the
  output frame word with its header and data views
*/
`default_nettype none

`include "adc_capture_consts.svh"

package adc_capture_pkg;

  // source of one 32-bit half of a data word
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ     = 2'd0,
    ROUTE_DAC_IQ     = 2'd1,
    ROUTE_ADC_COUNT  = 2'd2,
    ROUTE_GLBL_COUNT = 2'd3
  } route_e;

  // header view, written at frame start and end
  typedef struct packed {
    logic [`ADC_IQ_W-1:0] glbl_count;
    logic [`ADC_IQ_W-1:0] sample_count;
  } frame_hdr_t;

  // data view, two routed halves
  typedef struct packed {
    logic [`ADC_IQ_W-1:0] upper;
    logic [`ADC_IQ_W-1:0] lower;
  } frame_data_t;

  // one 64-bit word, decoded by position in the frame
  typedef union packed {
    frame_hdr_t  hdr;
    frame_data_t data;
  } frame_word_u;

endpackage

`default_nettype wire

// File: capture_ctrl_if.sv
/*
  capture control strobes from the sequencer to the frame assembler
*/
`timescale 1ns/1ps
`default_nettype none

interface capture_ctrl_if;

  // write a word this cycle, window and sample valid
  logic wr_en;
  // start header, one cycle
  logic wr_first;
  // end header
  logic wr_last;
  // alignment countdown running
  logic pad;

  modport sequencer (
    output wr_en,
    output wr_first,
    output wr_last,
    output pad
  );

  modport assembler (
    input wr_en,
    input wr_first,
    input wr_last,
    input pad
  );

endinterface

`default_nettype wire

// File: source_arbiter.sv
/*
  source arbiter: picks chirp dds or waveform player,
  steers init/enable to it and muxes its status back
*/
`timescale 1ns/1ps
`default_nettype none

module source_arbiter (
  input  wire        clk_245_76MHz,
  input  wire        cpu_reset,
  input  wire        chirp_init_i,
  input  wire        chirp_enable_i,
  input  wire [1:0]  source_ctrl_i,
  input  wire        dds_ready_i,
  input  wire        dds_done_i,
  input  wire        dds_active_i,
  input  wire        wfrm_ready_i,
  input  wire        wfrm_done_i,
  input  wire        wfrm_active_i,
  output logic       source_wfrm_o,
  output logic       dds_init_o,
  output logic       dds_enable_o,
  output logic       wfrm_init_o,
  output logic       wfrm_enable_o,
  output logic       chirp_ready_o,
  output logic       chirp_done_o,
  output logic       chirp_active_o
);

  logic [1:0] source_r;
  logic       sel_wfrm;

  // source frozen while a chirp is enabled
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      source_r <= 2'b00;
    end else if (!chirp_enable_i) begin
      source_r <= source_ctrl_i;
    end
  end

  // both bits set picks the waveform player
  assign sel_wfrm      = &source_r;
  assign source_wfrm_o = sel_wfrm;

  // strobes only reach the selected generator
  assign wfrm_init_o   = sel_wfrm & chirp_init_i;
  assign wfrm_enable_o = sel_wfrm & chirp_enable_i;
  assign dds_init_o    = ~sel_wfrm & chirp_init_i;
  assign dds_enable_o  = ~sel_wfrm & chirp_enable_i;

  // status from the selected generator
  assign chirp_ready_o  = sel_wfrm ? wfrm_ready_i : dds_ready_i;
  assign chirp_done_o   = sel_wfrm ? wfrm_done_i : dds_done_i;
  assign chirp_active_o = sel_wfrm ? wfrm_active_i : dds_active_i;

endmodule

`default_nettype wire

// File: capture_sequencer.sv
/*
  capture sequencer: waits out source latency, opens the adc window,
  marks start/end headers and pads each frame to a 64-word block
*/
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_consts.svh"

module capture_sequencer (
  input  wire                    clk_245_76MHz,
  input  wire                    cpu_reset,
  input  wire                    chirp_init_i,
  input  wire                    adc_enable_i,
  input  wire                    adc_valid_i,
  input  wire                    source_wfrm_i,
  capture_ctrl_if.sequencer      ctrl
);

  // enable stages, en_rr is the capture window
  logic                  en_r;
  logic                  en_rr;
  logic [`LAT_CNT_W-1:0] lat_cnt;
  logic                  lat_zero;
  logic [`ALIGN_W-1:0]   word_cnt;
  logic [`ALIGN_W-1:0]   align_cnt;
  logic                  pad;
  logic                  first_cond;
  logic                  pre_last;
  logic                  first_r;
  logic                  wr_en;

  assign lat_zero = (lat_cnt == '0);
  assign pad      = |align_cnt;
  assign wr_en    = en_rr & adc_valid_i;

  // window about to open
  assign first_cond = lat_zero & en_r & ~en_rr;
  // one cycle before the window would close
  assign pre_last = (lat_cnt == `LAT_CNT_W'(1)) & en_rr & ~en_r;

  //////////////////////////////////////////////////////////////////////
  // enable synchronizer and window
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_r  <= 1'b0;
      en_rr <= 1'b0;
    end else begin
      en_r <= adc_enable_i;
      // window moves only once latency and padding are done
      if (lat_zero && !pad) begin
        en_rr <= en_r;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // latency countdown
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      lat_cnt <= '0;
    end else if (chirp_init_i) begin
      // start latency of the active source
      if (source_wfrm_i) begin
        lat_cnt <= `LAT_CNT_W'(`DDS_WFRM_DELAY);
      end else begin
        lat_cnt <= `LAT_CNT_W'(`DDS_CHIRP_DELAY);
      end
    end else if (en_r && !adc_enable_i) begin
      // enable falling, drain the source pipeline
      if (source_wfrm_i) begin
        lat_cnt <= `LAT_CNT_W'(`DDS_WFRM_DELAY_END);
      end else begin
        lat_cnt <= `LAT_CNT_W'(`DDS_CHIRP_DELAY);
      end
    end else if (!lat_zero) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // word-in-frame count and alignment padding
  //////////////////////////////////////////////////////////////////////

  // counts modulo the block size
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      word_cnt <= '0;
    end else if (first_cond) begin
      word_cnt <= '0;
    end else if (wr_en) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  // words still needed so the end header lands on a block boundary
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      align_cnt <= '0;
    end else if (pre_last) begin
      align_cnt <= (word_cnt + 1'b1) ^ {`ALIGN_W{1'b1}};
    end else if (pad) begin
      align_cnt <= align_cnt - 1'b1;
    end
  end

  // start header one cycle after the window opens
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      first_r <= 1'b0;
    end else begin
      first_r <= first_cond;
    end
  end

  assign ctrl.wr_en    = wr_en;
  assign ctrl.wr_first = first_r;
  // end header once latency and padding have both run out
  assign ctrl.wr_last  = lat_zero & en_rr & ~en_r & ~pad;
  assign ctrl.pad      = pad;

endmodule

`default_nettype wire

// File: frame_assembler.sv
/*
  frame assembler: sample and global counters, half-word routing
  and the registered output word
*/
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_consts.svh"

module frame_assembler (
  input  wire                              clk_245_76MHz,
  input  wire                              cpu_reset,
  capture_ctrl_if.assembler                ctrl,
  input  wire [`ADC_HALF_W-1:0]            adc_i_i,
  input  wire [`ADC_HALF_W-1:0]            adc_q_i,
  input  wire [`ADC_HALF_W-1:0]            dac_i_i,
  input  wire [`ADC_HALF_W-1:0]            dac_q_i,
  input  wire [7:0]                        route_ctrl_i,
  output adc_capture_pkg::frame_word_u     frame_data_o,
  output logic                             frame_valid_o
);

  logic [`ADC_IQ_W-1:0]        sample_cnt;
  logic [`ADC_IQ_W-1:0]        glbl_cnt;
  adc_capture_pkg::route_e     route_l_r;
  adc_capture_pkg::route_e     route_u_r;
  logic                        hdr_sel;
  adc_capture_pkg::frame_word_u word_d;

  // one routed 32-bit half
  function automatic logic [`ADC_IQ_W-1:0] route_half(
    input adc_capture_pkg::route_e route
  );
    logic [`ADC_IQ_W-1:0] half;
    case (route)
      adc_capture_pkg::ROUTE_ADC_IQ:    half = {adc_i_i, adc_q_i};
      adc_capture_pkg::ROUTE_DAC_IQ:    half = {dac_i_i, dac_q_i};
      adc_capture_pkg::ROUTE_ADC_COUNT: half = sample_cnt;
      default:                          half = glbl_cnt;
    endcase
    return half;
  endfunction

  // sample count advances per written word, global count per cycle
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt <= '0;
      glbl_cnt   <= '0;
    end else begin
      glbl_cnt <= glbl_cnt + 1'b1;
      if (ctrl.wr_en) begin
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

  // route codes follow the control word one cycle late
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_l_r <= adc_capture_pkg::ROUTE_ADC_IQ;
      route_u_r <= adc_capture_pkg::ROUTE_ADC_IQ;
    end else begin
      route_l_r <= adc_capture_pkg::route_e'(route_ctrl_i[`CW_ROUTE_L_LSB +: 2]);
      route_u_r <= adc_capture_pkg::route_e'(route_ctrl_i[`CW_ROUTE_U_LSB +: 2]);
    end
  end

  // headers at frame start and at the padded frame end
  assign hdr_sel = ctrl.wr_first | (ctrl.wr_last & ~ctrl.pad);

  always_comb begin
    word_d = '0;
    if (hdr_sel) begin
      word_d.hdr.glbl_count   = glbl_cnt;
      word_d.hdr.sample_count = sample_cnt;
    end else begin
      word_d.data.upper = route_half(route_u_r);
      word_d.data.lower = route_half(route_l_r);
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= ctrl.wr_en;
    end
  end

  // payload register, held between writes
  always_ff @(posedge clk_245_76MHz) begin
    if (ctrl.wr_en) begin
      frame_data_o <= word_d;
    end
  end

endmodule

`default_nettype wire

// File: adc_capture_top.sv
/*
  adc capture framing core top: source arbiter, capture sequencer
  and frame assembler in the 245.76 MHz domain
*/
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_consts.svh"

module adc_capture_top (
  input  wire                    clk_245_76MHz,
  input  wire                    cpu_reset,
  // chirp control
  input  wire                    chirp_init_i,
  input  wire                    chirp_enable_i,
  input  wire                    adc_enable_i,
  input  wire [31:0]             control_word_i,
  // generator status
  input  wire                    dds_ready_i,
  input  wire                    dds_done_i,
  input  wire                    dds_active_i,
  input  wire                    wfrm_ready_i,
  input  wire                    wfrm_done_i,
  input  wire                    wfrm_active_i,
  // samples
  input  wire                    adc_valid_i,
  input  wire [`ADC_HALF_W-1:0]  adc_i_i,
  input  wire [`ADC_HALF_W-1:0]  adc_q_i,
  input  wire [`ADC_HALF_W-1:0]  dac_i_i,
  input  wire [`ADC_HALF_W-1:0]  dac_q_i,
  // generator steering
  output logic                   dds_init_o,
  output logic                   dds_enable_o,
  output logic                   wfrm_init_o,
  output logic                   wfrm_enable_o,
  // selected source status
  output logic                   chirp_ready_o,
  output logic                   chirp_done_o,
  output logic                   chirp_active_o,
  // framed output, no back-pressure
  output logic [`FRAME_W-1:0]    frame_data_o,
  output logic                   frame_valid_o
);

  logic source_wfrm;

  capture_ctrl_if i_ctrl_if ();

  source_arbiter i_source_arbiter (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .chirp_init_i   (chirp_init_i),
    .chirp_enable_i (chirp_enable_i),
    .source_ctrl_i  (control_word_i[`CW_SOURCE_LSB +: 2]),
    .dds_ready_i    (dds_ready_i),
    .dds_done_i     (dds_done_i),
    .dds_active_i   (dds_active_i),
    .wfrm_ready_i   (wfrm_ready_i),
    .wfrm_done_i    (wfrm_done_i),
    .wfrm_active_i  (wfrm_active_i),
    .source_wfrm_o  (source_wfrm),
    .dds_init_o     (dds_init_o),
    .dds_enable_o   (dds_enable_o),
    .wfrm_init_o    (wfrm_init_o),
    .wfrm_enable_o  (wfrm_enable_o),
    .chirp_ready_o  (chirp_ready_o),
    .chirp_done_o   (chirp_done_o),
    .chirp_active_o (chirp_active_o)
  );

  capture_sequencer i_capture_sequencer (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .chirp_init_i  (chirp_init_i),
    .adc_enable_i  (adc_enable_i),
    .adc_valid_i   (adc_valid_i),
    .source_wfrm_i (source_wfrm),
    .ctrl          (i_ctrl_if.sequencer)
  );

  // route fields sit in the low control byte
  frame_assembler i_frame_assembler (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .ctrl          (i_ctrl_if.assembler),
    .adc_i_i       (adc_i_i),
    .adc_q_i       (adc_q_i),
    .dac_i_i       (dac_i_i),
    .dac_q_i       (dac_q_i),
    .route_ctrl_i  (control_word_i[7:0]),
    .frame_data_o  (frame_data_o),
    .frame_valid_o (frame_valid_o)
  );

endmodule

`default_nettype wire

// File: adc_capture_asserts.sv
/*
  capture sequencer checks for header exclusivity, a one-cycle start
  header and no write opening during the latency countdown
*/
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_consts.svh"

module adc_capture_asserts (
  input wire                  clk_245_76MHz,
  input wire                  cpu_reset,
  input wire                  wr_en_i,
  input wire                  wr_first_i,
  input wire                  wr_last_i,
  input wire [`LAT_CNT_W-1:0] lat_cnt_i
);

  // number of failed assertions
  int fail_cnt = 0;

  // start and end header never share one write
  first_last_excl: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      !(wr_first_i && wr_last_i)
  ) else begin
    fail_cnt++;
    $error("wr_first and wr_last high in the same cycle");
  end

  // start header is a single-cycle level
  first_one_cycle: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      wr_first_i |=> !wr_first_i
  ) else begin
    fail_cnt++;
    $error("wr_first held longer than one cycle");
  end

  // window opens only after the source latency ran out
  wr_en_after_latency: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      $rose(wr_en_i) |-> (lat_cnt_i == '0)
  ) else begin
    fail_cnt++;
    $error("wr_en rose with latency counter at %0d", lat_cnt_i);
  end

endmodule

bind capture_sequencer adc_capture_asserts i_adc_capture_asserts (
  .clk_245_76MHz (clk_245_76MHz),
  .cpu_reset     (cpu_reset),
  .wr_en_i       (ctrl.wr_en),
  .wr_first_i    (ctrl.wr_first),
  .wr_last_i     (ctrl.wr_last),
  .lat_cnt_i     (lat_cnt)
);

`default_nettype wire

// File: tb_adc_capture.sv
/*
  adc capture core testbench covering frames from both sources, routed data,
  header counts, 64-word alignment, start latency and source steering
*/
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_consts.svh"

module tb_adc_capture;

  localparam int N_FRAMES   = 4;
  localparam int START_WAIT = 64;
  localparam int END_WAIT   = 256;

  // per-frame source bits 9:8 and window length after the first word
  logic [1:0] frame_src [N_FRAMES] = '{2'b00, 2'b11, 2'b01, 2'b11};
  int         frame_len [N_FRAMES] = '{10, 70, 3, 127};

  logic        clk_245_76MHz = 1'b0;
  logic        cpu_reset;
  logic        chirp_init_i, chirp_enable_i, adc_enable_i, adc_valid_i;
  logic [31:0] control_word_i;
  logic        dds_ready_i, dds_done_i, dds_active_i;
  logic        wfrm_ready_i, wfrm_done_i, wfrm_active_i;
  logic [15:0] adc_i_i, adc_q_i, dac_i_i, dac_q_i;
  logic        dds_init_o, dds_enable_o, wfrm_init_o, wfrm_enable_o;
  logic        chirp_ready_o, chirp_done_o, chirp_active_o;
  logic [63:0] frame_data_o;
  logic        frame_valid_o;

  int          n_checks = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  int          assert_errs = 0;
  bit          timed_out = 1'b0;
  logic [31:0] rng_state = 32'd72;

  // compare side state where history index 0 is the cycle ending now
  logic [31:0] h_adc [3];
  logic [31:0] h_dac [3];
  logic [31:0] h_glbl [3];
  logic [7:0]  h_route [3];
  logic [31:0] glbl_model = '0;
  logic        src_model = 1'b0;
  bit          seen_reset = 1'b0;
  bit          pend_valid = 1'b0;
  bit          pend_first;
  logic [63:0] pend_word, pend_exp;
  logic [31:0] pend_scnt;
  logic [31:0] nwr = '0;
  logic [31:0] last_glbl = '0;
  int          run_len = 0;
  int          frames_seen = 0;

  adc_capture_top i_adc_capture_top (.*);

  always #5 clk_245_76MHz = ~clk_245_76MHz;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // worst case cycles over reset and each frame's setup, latency, waits and window
  function automatic int run_budget();
    int total;
    total = 16;
    for (int f = 0; f < N_FRAMES; f++) begin
      total += 5 + `DDS_WFRM_DELAY + START_WAIT + frame_len[f] + END_WAIT;
    end
    return total;
  endfunction

  function automatic logic [31:0] routed_half(
    input logic [1:0] code, input logic [31:0] adc_iq, dac_iq, scnt, gcnt
  );
    case (code)
      adc_capture_pkg::ROUTE_ADC_IQ:    return adc_iq;
      adc_capture_pkg::ROUTE_DAC_IQ:    return dac_iq;
      adc_capture_pkg::ROUTE_ADC_COUNT: return scnt;
      default:                          return gcnt;
    endcase
  endfunction

  // expected data word from the routes and samples of the write cycle
  function automatic logic [63:0] expected_data(
    input logic [7:0] route, input logic [31:0] adc_iq, dac_iq, scnt, gcnt
  );
    logic [31:0] upper;
    logic [31:0] lower;
    upper = routed_half(route[`CW_ROUTE_U_LSB +: 2], adc_iq, dac_iq, scnt, gcnt);
    lower = routed_half(route[`CW_ROUTE_L_LSB +: 2], adc_iq, dac_iq, scnt, gcnt);
    return {upper, lower};
  endfunction

  task automatic check_value(input logic [63:0] got, exp, input string what);
    n_checks++;
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_header(input logic [63:0] word, input logic [31:0] scnt,
                              input string what);
    check_value(word[31:0], scnt, {what, " sample count"});
    check_value(word[63:32] > last_glbl, 1, {what, " global count increasing"});
    last_glbl = word[63:32];
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(negedge clk_245_76MHz);
    rng_state = xorshift32(rng_state);
    {adc_i_i, adc_q_i} = rng_state;
    rng_state = xorshift32(rng_state);
    {dac_i_i, dac_q_i} = rng_state;
    rng_state = xorshift32(rng_state);
    control_word_i[`CW_ROUTE_L_LSB +: 2] = rng_state[1:0];
    control_word_i[`CW_ROUTE_U_LSB +: 2] = rng_state[5:4];
    {dds_ready_i, dds_done_i, dds_active_i}    = rng_state[10:8];
    {wfrm_ready_i, wfrm_done_i, wfrm_active_i} = rng_state[13:11];
    // source bits move freely while the chirp is enabled
    if (chirp_enable_i) begin
      control_word_i[`CW_SOURCE_LSB +: 2] = rng_state[17:16];
    end
  endtask

  task automatic run_frame(input int f);
    int lat;
    int waited;
    lat = (frame_src[f] == 2'b11) ? `DDS_WFRM_DELAY : `DDS_CHIRP_DELAY;
    next_cycle();
    control_word_i[`CW_SOURCE_LSB +: 2] = frame_src[f];
    repeat (2) next_cycle();
    // init and adc enable in the same cycle
    chirp_init_i   = 1'b1;
    chirp_enable_i = 1'b1;
    adc_enable_i   = 1'b1;
    for (int i = 0; i <= lat; i++) begin
      next_cycle();
      chirp_init_i = 1'b0;
      check_value(frame_valid_o, 0, "frame_valid_o inside start latency");
    end
    waited = 0;
    while (!frame_valid_o && waited < START_WAIT) begin
      next_cycle();
      waited++;
    end
    if (!frame_valid_o) begin
      other_errs++;
      timed_out = 1'b1;
      $display("frame %0d did not start within %0d cycles", f, START_WAIT);
    end else begin
      repeat (frame_len[f]) next_cycle();
      adc_enable_i = 1'b0;
      // padding keeps the word stream running until the end header
      waited = 0;
      while (frame_valid_o && waited < END_WAIT) begin
        next_cycle();
        waited++;
      end
      if (frame_valid_o) begin
        other_errs++;
        timed_out = 1'b1;
        $display("frame %0d did not end within %0d cycles", f, END_WAIT);
      end
      chirp_enable_i = 1'b0;
      control_word_i[`CW_SOURCE_LSB +: 2] = frame_src[f];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare against pre-edge values at each rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_245_76MHz) begin
    for (int i = 2; i > 0; i--) begin
      h_adc[i]   = h_adc[i-1];
      h_dac[i]   = h_dac[i-1];
      h_glbl[i]  = h_glbl[i-1];
      h_route[i] = h_route[i-1];
    end
    h_adc[0]   = {adc_i_i, adc_q_i};
    h_dac[0]   = {dac_i_i, dac_q_i};
    h_glbl[0]  = glbl_model;
    h_route[0] = control_word_i[7:0];
    glbl_model = cpu_reset ? '0 : glbl_model + 1;
    if (seen_reset) begin
      // steering and status against the selected source
      check_value(dds_init_o, !src_model & chirp_init_i, "dds_init_o");
      check_value(dds_enable_o, !src_model & chirp_enable_i, "dds_enable_o");
      check_value(wfrm_init_o, src_model & chirp_init_i, "wfrm_init_o");
      check_value(wfrm_enable_o, src_model & chirp_enable_i, "wfrm_enable_o");
      check_value(chirp_ready_o, src_model ? wfrm_ready_i : dds_ready_i, "chirp_ready_o");
      check_value(chirp_done_o, src_model ? wfrm_done_i : dds_done_i, "chirp_done_o");
      check_value(chirp_active_o, src_model ? wfrm_active_i : dds_active_i,
                  "chirp_active_o");
      // word on the output now was written two edges back
      if (frame_valid_o) begin
        if (pend_valid && pend_first) begin
          check_header(pend_word, pend_scnt, "start header");
        end else if (pend_valid) begin
          check_value(pend_word, pend_exp, "data word");
        end
        pend_exp   = expected_data(h_route[2], h_adc[1], h_dac[1], nwr, h_glbl[1]);
        pend_first = !pend_valid;
        pend_valid = 1'b1;
        pend_word  = frame_data_o;
        pend_scnt  = nwr;
        run_len    = pend_first ? 1 : run_len + 1;
        nwr++;
      end else if (pend_valid) begin
        if (pend_first) begin
          other_errs++;
          $display("frame %0d held a single word, no end header", frames_seen);
        end else begin
          check_header(pend_word, pend_scnt, "end header");
          check_value(run_len % (1 << `ALIGN_W), 0, "frame length modulo block size");
        end
        frames_seen++;
        pend_valid = 1'b0;
      end
    end
    if (cpu_reset) begin
      src_model = 1'b0;
    end else if (!chirp_enable_i) begin
      src_model = &control_word_i[`CW_SOURCE_LSB +: 2];
    end
    seen_reset |= cpu_reset;
  end

  initial begin
    repeat (run_budget()) @(posedge clk_245_76MHz);
    $display("watchdog expired after %0d cycles, run did not finish", run_budget());
    $display("TB FAILED");
    $finish;
  end

  initial begin
    cpu_reset      = 1'b1;
    chirp_init_i   = 1'b0;
    chirp_enable_i = 1'b0;
    adc_enable_i   = 1'b0;
    adc_valid_i    = 1'b0;
    control_word_i = '0;
    {dds_ready_i, dds_done_i, dds_active_i}    = '0;
    {wfrm_ready_i, wfrm_done_i, wfrm_active_i} = '0;
    {adc_i_i, adc_q_i, dac_i_i, dac_q_i}       = '0;
    repeat (5) @(negedge clk_245_76MHz);
    cpu_reset   = 1'b0;
    adc_valid_i = 1'b1;
    @(negedge clk_245_76MHz);
    // quiet outputs right after reset
    check_value(frame_valid_o, 0, "frame_valid_o after reset");
    check_value({dds_init_o, dds_enable_o, wfrm_init_o, wfrm_enable_o}, 0,
                "steering strobes after reset");
    for (int f = 0; f < N_FRAMES && !timed_out; f++) begin
      run_frame(f);
    end
    repeat (8) next_cycle();
    check_value(frames_seen, N_FRAMES, "frames seen");
    assert_errs = i_adc_capture_top.i_capture_sequencer.i_adc_capture_asserts.fail_cnt;
    $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             n_checks, value_errs, other_errs, assert_errs);
    if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
adc_capture_pkg.sv
capture_ctrl_if.sv
source_arbiter.sv
capture_sequencer.sv
frame_assembler.sv
adc_capture_top.sv
adc_capture_asserts.sv
tb_adc_capture.sv

// File: Bender.yml
package:
  name: adc_capture

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - adc_capture_pkg.sv
      - capture_ctrl_if.sv
      - source_arbiter.sv
      - capture_sequencer.sv
      - frame_assembler.sv
      - adc_capture_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - adc_capture_asserts.sv
      - tb_adc_capture.sv
